// File: am2301_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module am2301_asserts (
	input logic                    clk_1us,
	input logic                    rsi_MRST_reset,
	input sensor_pkg::line_state_t state,
	input logic                    line_oe,
	input logic                    line_out,
	input logic                    fall,
	input logic                    frame_ready
);
	import sensor_pkg::*;

	// failed assertions so far
	int fail_cnt = 0;

	// drive follows the state one cycle late
	property low_when_driven;
		@(posedge clk_1us) disable iff (rsi_MRST_reset)
		(line_oe && ($past(state) != IDLE)) |-> !line_out;
	endproperty

	property released_after_start;
		@(posedge clk_1us) disable iff (rsi_MRST_reset)
		(state inside {RESP_LOW, RESP_HIGH, BIT_LOW, BIT_HIGH, READY}) |-> !line_oe;
	endproperty

	// ready only comes from the last fall
	property ready_after_fall;
		@(posedge clk_1us) disable iff (rsi_MRST_reset)
		$rose(frame_ready) |-> $past(fall);
	endproperty

	a_low_when_driven: assert property (low_when_driven)
		else begin
			$error("line driven high outside IDLE");
			fail_cnt++;
		end

	a_released_after_start: assert property (released_after_start)
		else begin
			$error("line still driven after the response started");
			fail_cnt++;
		end

	a_ready_after_fall: assert property (ready_after_fall)
		else begin
			$error("frame_ready rose without a fall before it");
			fail_cnt++;
		end

endmodule

bind am2301_bus_ctrl am2301_asserts u_asserts (
	.clk_1us        (clk_1us),
	.rsi_MRST_reset (rsi_MRST_reset),
	.state          (state),
	.line_oe        (line_oe),
	.line_out       (line_out),
	.fall           (fall),
	.frame_ready    (frame_ready)
);

`default_nettype wire

// File: am2301_bit_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module am2301_bit_decoder #(
	parameter int unsigned HIGH_WIDTH = 40
) (
	input  logic                   clk_1us,
	input  logic                   rsi_MRST_reset,
	input  sensor_pkg::bit_evt_t   evt,
	output sensor_pkg::data_word_t data,
	output logic                   last_bit
);
	import sensor_pkg::*;

	localparam cycle_cnt_t HIGH_CNT = cycle_cnt_t'(HIGH_WIDTH);
	localparam logic [BIT_IDX_W-1:0] LAST_IDX = BIT_IDX_W'(DATA_W - 1);

	cycle_cnt_t           stamp;
	logic [CNT_W:0]       thresh;
	logic                 bit_val;
	logic [BIT_IDX_W-1:0] bit_cnt;

	// one spare bit so the sum cannot wrap
	assign thresh = {1'b0, stamp} + {1'b0, HIGH_CNT};

	// long high phase means a one
	assign bit_val = ({1'b0, evt.count} > thresh);

	// timestamp and shift register
	always_ff @(posedge clk_1us) begin
		if (evt.frame_clear) begin
			stamp <= '0;
			data  <= '0;
		end else begin
			if (evt.rise) begin
				stamp <= evt.count;
			end
			if (evt.fall) begin
				// msb arrives first
				data <= {data[DATA_W-2:0], bit_val};
			end
		end
	end

	// bits shifted so far in this frame
	always_ff @(posedge clk_1us or posedge rsi_MRST_reset) begin
		if (rsi_MRST_reset) begin
			bit_cnt <= '0;
		end else if (evt.frame_clear) begin
			bit_cnt <= '0;
		end else if (evt.fall) begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// next fall closes the frame
	assign last_bit = (bit_cnt == LAST_IDX);

endmodule

`default_nettype wire

// File: am2301_bus_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module am2301_bus_ctrl #(
	parameter int unsigned START_WIDTH = 1000,
	parameter int unsigned CYCLE_LIMIT = 2000000
) (
	input  logic                 clk_1us,
	input  logic                 rsi_MRST_reset,
	input  logic                 line_in,
	input  logic                 last_bit,
	output logic                 line_oe,
	output logic                 line_out,
	output sensor_pkg::bit_evt_t evt,
	output logic                 frame_ready
);
	import sensor_pkg::*;

	localparam cycle_cnt_t START_CNT = cycle_cnt_t'(START_WIDTH);
	localparam cycle_cnt_t LIMIT_CNT = cycle_cnt_t'(CYCLE_LIMIT);

	line_state_t state;
	line_state_t next_state;
	cycle_cnt_t  frame_cnt;
	logic        timeout;
	logic        rise;
	logic        fall;

	assign timeout = (frame_cnt > LIMIT_CNT);

	// edges of the data line as seen by the bit phases
	assign rise = (state == BIT_LOW) && line_in;
	assign fall = (state == BIT_HIGH) && !line_in;

	// state register and frame counter
	always_ff @(posedge clk_1us or posedge rsi_MRST_reset) begin
		if (rsi_MRST_reset) begin
			state     <= IDLE;
			frame_cnt <= '0;
		end else if (timeout) begin
			// stalled sensor or stale ready word, start over
			state     <= IDLE;
			frame_cnt <= '0;
		end else begin
			state     <= next_state;
			frame_cnt <= frame_cnt + 1'b1;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				next_state = START_DRIVE;
			end
			START_DRIVE: begin
				if (frame_cnt > START_CNT) begin
					next_state = RELEASE;
				end
			end
			// sensor pulls low to answer
			RELEASE: begin
				if (!line_in) begin
					next_state = RESP_LOW;
				end
			end
			RESP_LOW: begin
				if (line_in) begin
					next_state = RESP_HIGH;
				end
			end
			RESP_HIGH: begin
				if (!line_in) begin
					next_state = BIT_LOW;
				end
			end
			BIT_LOW: begin
				if (rise) begin
					next_state = BIT_HIGH;
				end
			end
			BIT_HIGH: begin
				if (fall) begin
					next_state = last_bit ? READY : BIT_LOW;
				end
			end
			// held until the frame counter runs out
			READY: begin
				next_state = READY;
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	// line drive lags the state by one cycle
	always_ff @(posedge clk_1us or posedge rsi_MRST_reset) begin
		if (rsi_MRST_reset) begin
			line_oe  <= 1'b1;
			line_out <= 1'b1;
		end else begin
			case (state)
				IDLE: begin
					line_oe  <= 1'b1;
					line_out <= 1'b1;
				end
				START_DRIVE: begin
					line_oe  <= 1'b1;
					line_out <= 1'b0;
				end
				default: begin
					line_oe  <= 1'b0;
					line_out <= 1'b1;
				end
			endcase
		end
	end

	always_comb begin
		evt.frame_clear = (state == IDLE);
		evt.rise        = rise;
		evt.fall        = fall;
		evt.count       = frame_cnt;
	end

	assign frame_ready = (state == READY);

endmodule

`default_nettype wire

// File: am2301_regs.sv
`timescale 1ns/1ps
`default_nettype none

module am2301_regs (
	input  logic                   clk_1us,
	input  logic                   rsi_MRST_reset,
	input  sensor_pkg::reg_addr_t  address,
	input  sensor_pkg::data_word_t data,
	input  logic                   frame_ready,
	output sensor_pkg::reg_data_t  readdata
);
	import sensor_pkg::*;

	localparam int RD_W = $bits(reg_data_t);
	localparam reg_data_t WIDTH_VAL = reg_data_t'(DATA_W);

	reg_data_t status_word;
	reg_data_t data_word;

	// ready flag sits in bit 0
	assign status_word = {{(RD_W - 1){1'b0}}, frame_ready};
	assign data_word   = reg_data_t'(data);

	// refreshed every cycle, one cycle after the address
	always_ff @(posedge clk_1us or posedge rsi_MRST_reset) begin
		if (rsi_MRST_reset) begin
			readdata <= '0;
		end else begin
			case (address)
				REG_WIDTH: begin
					readdata <= WIDTH_VAL;
				end
				REG_ID0: begin
					readdata <= DEVICE_ID;
				end
				REG_ID1: begin
					readdata <= DEVICE_ID;
				end
				REG_DATA: begin
					readdata <= data_word;
				end
				REG_STATUS: begin
					readdata <= status_word;
				end
				// unmapped addresses read as zero
				default: begin
					readdata <= '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: am2301_top.sv
`timescale 1ns/1ps
`default_nettype none

module am2301_top #(
	parameter int unsigned START_WIDTH = 1000,
	parameter int unsigned HIGH_WIDTH  = 40,
	parameter int unsigned CYCLE_LIMIT = 2000000
) (
	input  logic                  clk_1us,
	input  logic                  rsi_MRST_reset,
	input  sensor_pkg::reg_addr_t address,
	output sensor_pkg::reg_data_t readdata,
	inout  wire                   sda
);
	import sensor_pkg::*;

	logic       line_oe;
	logic       line_out;
	logic       line_in;
	logic       last_bit;
	logic       frame_ready;
	bit_evt_t   evt;
	data_word_t data;

	// pad, released line is pulled high externally
	assign sda = line_oe ? line_out : 1'bz;

	// own drive is masked so the start pulse is not taken as a response
	assign line_in = line_oe ? 1'b1 : sda;

	am2301_bus_ctrl #(
		.START_WIDTH (START_WIDTH),
		.CYCLE_LIMIT (CYCLE_LIMIT)
	) u_bus_ctrl (
		.clk_1us        (clk_1us),
		.rsi_MRST_reset (rsi_MRST_reset),
		.line_in        (line_in),
		.last_bit       (last_bit),
		.line_oe        (line_oe),
		.line_out       (line_out),
		.evt            (evt),
		.frame_ready    (frame_ready)
	);

	am2301_bit_decoder #(
		.HIGH_WIDTH (HIGH_WIDTH)
	) u_bit_decoder (
		.clk_1us        (clk_1us),
		.rsi_MRST_reset (rsi_MRST_reset),
		.evt            (evt),
		.data           (data),
		.last_bit       (last_bit)
	);

	// register read port
	am2301_regs u_regs (
		.clk_1us        (clk_1us),
		.rsi_MRST_reset (rsi_MRST_reset),
		.address        (address),
		.data           (data),
		.frame_ready    (frame_ready),
		.readdata       (readdata)
	);

endmodule

`default_nettype wire

// File: flist.f
sensor_pkg.sv
am2301_bit_decoder.sv
am2301_bus_ctrl.sv
am2301_regs.sv
am2301_top.sv
am2301_asserts.sv
tb_am2301.sv

// File: sensor_pkg.sv
`default_nettype none

package sensor_pkg;

	// frame geometry
	localparam int DATA_W = 32;

	typedef logic [DATA_W-1:0] data_word_t;

	// frame cycle counter, one count per microsecond
	localparam int CNT_W = 25;

	typedef logic [CNT_W-1:0] cycle_cnt_t;

	// enough for 0..31 shifted bits
	localparam int BIT_IDX_W = 5;

	// register read port
	typedef logic [2:0] reg_addr_t;
	typedef logic [31:0] reg_data_t;

	localparam reg_data_t DEVICE_ID = 32'hEA68_0003;

	localparam reg_addr_t REG_WIDTH  = 3'd0;
	localparam reg_addr_t REG_ID0    = 3'd1;
	localparam reg_addr_t REG_ID1    = 3'd2;
	localparam reg_addr_t REG_DATA   = 3'd3;
	localparam reg_addr_t REG_STATUS = 3'd4;

	// line sequencing states
	typedef enum logic [3:0] {
		IDLE,
		START_DRIVE,
		RELEASE,
		RESP_LOW,
		RESP_HIGH,
		BIT_LOW,
		BIT_HIGH,
		READY
	} line_state_t;

	// controller to decoder, one per cycle
	typedef struct packed {
		logic       frame_clear;
		logic       rise;
		logic       fall;
		cycle_cnt_t count;
	} bit_evt_t;

endpackage

`default_nettype wire

// File: tb_am2301.sv
`timescale 1ns/1ps
`default_nettype none

module tb_am2301;
	import sensor_pkg::*;

	localparam int unsigned START_WIDTH = 20;
	localparam int unsigned HIGH_WIDTH  = 40;
	localparam int unsigned CYCLE_LIMIT = 6000;

	localparam logic [31:0] SEED = 32'h7b76_20ce;

	// sensor timing in clock cycles
	localparam int RESP_CYCLES = 80;
	localparam int LOW_CYCLES  = 50;
	localparam int ONE_CYCLES  = 70;
	localparam int ZERO_CYCLES = 26;
	localparam int TAIL_CYCLES = 50;
	localparam int MIN_LOW     = 15;

	localparam int START_TIMEOUT = CYCLE_LIMIT + 2000;
	localparam int POLL_LIMIT    = CYCLE_LIMIT;

	logic       clk_1us;
	logic       rsi_MRST_reset;
	reg_addr_t  address;
	reg_data_t  readdata;
	wire        sda;
	logic       sensor_low;
	int         start_len;
	data_word_t word_a;
	data_word_t word_b;
	data_word_t word_c;
	data_word_t word_d;

	pullup (sda);

	// open-drain sensor output
	assign sda = sensor_low ? 1'b0 : 1'bz;

	am2301_top #(
		.START_WIDTH (START_WIDTH),
		.HIGH_WIDTH  (HIGH_WIDTH),
		.CYCLE_LIMIT (CYCLE_LIMIT)
	) uut (
		.clk_1us        (clk_1us),
		.rsi_MRST_reset (rsi_MRST_reset),
		.address        (address),
		.readdata       (readdata),
		.sda            (sda)
	);

	always begin
		#10 clk_1us = ~clk_1us;
	end

	// a bit decodes as one when its high phase outlasts HIGH_WIDTH
	function automatic data_word_t ref_decode(input data_word_t word, input int zero_w,
			input int one_w);
		data_word_t res;
		int         w;
		res = '0;
		for (int i = 0; i < DATA_W; i++) begin
			w = word[i] ? one_w : zero_w;
			res[i] = (w > int'(HIGH_WIDTH));
		end
		return res;
	endfunction

	task automatic abort_run();
		$display("Test failures found");
		$fatal(1);
	endtask

	// bound checker on the bus controller
	always @(negedge clk_1us) begin
		if (uut.u_bus_ctrl.u_asserts.fail_cnt != 0) begin
			$display("a bound assertion on the bus controller failed at %0t", $time);
			abort_run();
		end
	end

	task automatic read_reg(input reg_addr_t addr, output reg_data_t val);
		@(negedge clk_1us);
		address = addr;
		// registered read port
		@(negedge clk_1us);
		val = readdata;
	endtask

	task automatic check_reg(input reg_addr_t addr, input reg_data_t expected);
		reg_data_t got;
		read_reg(addr, got);
		if (got !== expected) begin
			$display("FAILED at %0t: register %0d read %h, expected %h",
				$time, addr, got, expected);
			abort_run();
		end
	endtask

	task automatic check_data(input data_word_t expected);
		reg_data_t got;
		read_reg(REG_DATA, got);
		if (data_word_t'(got) !== expected) begin
			$display("FAILED at %0t: sensor word read %h, expected %h", $time, got, expected);
			abort_run();
		end
	endtask

	task automatic check_pulse(input int low_len);
		if (low_len < int'(START_WIDTH)) begin
			$display("FAILED at %0t: start pulse of %0d cycles, expected at least %0d",
				$time, low_len, START_WIDTH);
			abort_run();
		end
	endtask

	task automatic wait_status(input logic level);
		reg_data_t val;
		int        polls;
		polls = 0;
		read_reg(REG_STATUS, val);
		while (val[0] !== level && polls < POLL_LIMIT) begin
			read_reg(REG_STATUS, val);
			polls++;
		end
		if (val[0] !== level) begin
			$display("timeout at %0t: ready flag never went to %0b", $time, level);
			abort_run();
		end
	endtask

	task automatic hold_status_low(input int n_reads);
		for (int i = 0; i < n_reads; i++) begin
			check_reg(REG_STATUS, '0);
		end
	endtask

	// low for a while, then released by the controller
	task automatic wait_start(output int low_len);
		int   run;
		int   cycles;
		logic seen;
		run = 0;
		cycles = 0;
		seen = 1'b0;
		low_len = 0;
		while (!seen && cycles < START_TIMEOUT) begin
			@(negedge clk_1us);
			cycles++;
			if (sda === 1'b0) begin
				run++;
			end else if (run >= MIN_LOW) begin
				seen = 1'b1;
				low_len = run;
			end else begin
				run = 0;
			end
		end
		if (!seen) begin
			$display("timeout at %0t: the controller sent no start pulse", $time);
			abort_run();
		end
	endtask

	task automatic sensor_frame(input data_word_t word, input int n_bits, output int low_len);
		int i;
		wait_start(low_len);
		sensor_low = 1'b1;
		repeat (RESP_CYCLES) @(negedge clk_1us);
		sensor_low = 1'b0;
		repeat (RESP_CYCLES) @(negedge clk_1us);
		for (i = DATA_W - 1; i >= DATA_W - n_bits; i--) begin
			sensor_low = 1'b1;
			repeat (LOW_CYCLES) @(negedge clk_1us);
			sensor_low = 1'b0;
			if (word[i]) begin
				repeat (ONE_CYCLES) @(negedge clk_1us);
			end else begin
				repeat (ZERO_CYCLES) @(negedge clk_1us);
			end
		end
		// a stalled sensor just leaves the line released
		if (n_bits == DATA_W) begin
			sensor_low = 1'b1;
			repeat (TAIL_CYCLES) @(negedge clk_1us);
			sensor_low = 1'b0;
		end
	endtask

	initial begin
		clk_1us = 1'b0;
		rsi_MRST_reset = 1'b1;
		address = REG_STATUS;
		sensor_low = 1'b0;
		start_len = 0;
		void'($urandom(SEED));
		word_a = $urandom();
		word_b = $urandom();
		word_c = $urandom();
		word_d = $urandom();

		repeat (2) @(negedge clk_1us);
		rsi_MRST_reset = 1'b0;
		if (sda !== 1'b1) begin
			$display("FAILED at %0t: sda read %b before the start pulse, expected 1",
				$time, sda);
			abort_run();
		end

		// first frame, register map read alongside
		fork
			sensor_frame(word_a, DATA_W, start_len);
			begin
				check_reg(REG_STATUS, '0);
				check_reg(REG_WIDTH, 32'd32);
				check_reg(REG_ID0, DEVICE_ID);
				check_reg(REG_ID1, DEVICE_ID);
				check_reg(3'd6, '0);
			end
		join
		check_pulse(start_len);
		wait_status(1'b1);
		check_data(ref_decode(word_a, ZERO_CYCLES, ONE_CYCLES));

		// frame counter runs out, next frame starts on its own
		fork
			sensor_frame(word_b, DATA_W, start_len);
			wait_status(1'b0);
		join
		check_pulse(start_len);
		wait_status(1'b1);
		check_data(ref_decode(word_b, ZERO_CYCLES, ONE_CYCLES));

		// sensor stalls after 10 bits
		fork
			sensor_frame(word_c, 10, start_len);
			wait_status(1'b0);
		join
		check_pulse(start_len);
		fork
			sensor_frame(word_d, DATA_W, start_len);
			hold_status_low(1000);
		join
		check_pulse(start_len);
		wait_status(1'b1);
		check_data(ref_decode(word_d, ZERO_CYCLES, ONE_CYCLES));

		if (uut.u_bus_ctrl.u_asserts.fail_cnt == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			$display("a bound assertion on the bus controller failed before the end");
			abort_run();
		end
	end

endmodule

`default_nettype wire
